// File: common/RvTypes.sv
package RvTypes;

    localparam int DataBits     = 32;                        // Register and memory word
    localparam int RegAddrBits  = 5;                         // x0 to x31
    localparam int RegCount     = 1 << RegAddrBits;          // Architectural registers
    localparam int Funct3Bits   = 3;                         // Width code field
    localparam int LaneCount    = DataBits / 8;              // Byte lanes per word

    localparam int DataMemWords = 256;                       // Data memory depth in words
    localparam int DataAddrBits = $clog2(DataMemWords) + 2;  // Byte address, 10 bits

    typedef logic [DataBits-1:0]     Data;                   // One data word
    typedef logic [RegAddrBits-1:0]  RegAddr;                // Register index
    typedef logic [DataAddrBits-1:0] DataAddr;               // Byte address into data memory
    typedef logic [Funct3Bits-1:0]   Funct3;                 // Access width code
    typedef logic [LaneCount-1:0]    ByteEnable;             // One bit per byte lane

    // Load and store width codes, as in the funct3 field of the instruction
    localparam Funct3 FunctByte  = 3'd0;                     // LB / SB
    localparam Funct3 FunctHalf  = 3'd1;                     // LH / SH
    localparam Funct3 FunctWord  = 3'd2;                     // LW / SW
    localparam Funct3 FunctByteU = 3'd4;                     // LBU
    localparam Funct3 FunctHalfU = 3'd5;                     // LHU

endpackage

// File: memoryStage/DataMemory.sv
module DataMemory (
    input  logic                                i_clock,       // Clock
    input  logic [RvTypes::DataAddrBits-1:2]    i_wordAddr,    // Word index
    input  RvTypes::ByteEnable                  i_byteEnable,  // Lanes to write
    input  RvTypes::Data                        i_writeData,   // Lane-aligned data
    input  logic                                i_write,       // Write strobe
    output RvTypes::Data                        o_readData     // Word at i_wordAddr
);

    RvTypes::Data memory [RvTypes::DataMemWords];  // No reset, contents undefined

    // Byte-lane write on the clock edge
    always_ff @(posedge i_clock) begin
        if (i_write) begin
            for (int lane = 0; lane < RvTypes::LaneCount; lane++) begin
                if (i_byteEnable[lane]) begin
                    memory[i_wordAddr][lane*8 +: 8] <= i_writeData[lane*8 +: 8];
                end
            end
        end
    end

    assign o_readData = memory[i_wordAddr];  // Asynchronous read

endmodule

// File: memoryStage/MemoryStage.sv
module MemoryStage (
    input  logic           i_clock,        // Clock for the memory write
    input  logic           i_flush,        // Cancel the instruction in MEM
    input  logic           i_regWrEnable,  // From EX/MEM
    input  logic           i_isLoad,       // Load in MEM
    input  logic           i_isStore,      // Store in MEM
    input  RvTypes::Funct3 i_funct3,       // Access width code
    input  RvTypes::Data   i_aluResult,    // Byte address or ALU value
    input  RvTypes::Data   i_storeData,    // Unaligned store value

    output RvTypes::Data   o_result,       // Value for write-back
    output logic           o_regWrEnable   // Passed on to MEM/WB
);

    logic [1:0]         byteOffset;     // Lane of the access
    RvTypes::DataAddr   byteAddr;       // Address bits inside the memory
    RvTypes::ByteEnable byteEnable;     // Lanes written by a store
    RvTypes::Data       laneData;       // Store data replicated to lanes
    logic               memWrite;       // Store that survives flush
    RvTypes::Data       readData;       // Whole addressed word
    RvTypes::Data       shiftedRead;    // Addressed byte moved to bits 7:0
    RvTypes::Data       shiftedHalf;    // Addressed half moved to bits 15:0
    logic [7:0]         loadByte;
    logic [15:0]        loadHalf;
    RvTypes::Data       loadValue;      // Extended load result

    assign byteAddr   = i_aluResult[RvTypes::DataAddrBits-1:0];  // Upper bits ignored
    assign byteOffset = byteAddr[1:0];
    assign memWrite   = i_isStore & ~i_flush;  // Flushed store never reaches memory

    // Store lane placement, misaligned halves drop bit 0
    always_comb begin
        case (i_funct3)
            RvTypes::FunctByte: begin
                laneData   = {RvTypes::LaneCount{i_storeData[7:0]}};
                byteEnable = RvTypes::ByteEnable'(4'b0001) << byteOffset;
            end
            RvTypes::FunctHalf: begin
                laneData   = {(RvTypes::LaneCount / 2){i_storeData[15:0]}};
                byteEnable = RvTypes::ByteEnable'(4'b0011) << {byteOffset[1], 1'b0};
            end
            RvTypes::FunctWord: begin
                laneData   = i_storeData;
                byteEnable = '1;
            end
            default: begin                     // Not a store width
                laneData   = i_storeData;
                byteEnable = '0;
            end
        endcase
    end

    DataMemory i_dataMemory (
        .i_clock      (i_clock),
        .i_wordAddr   (byteAddr[RvTypes::DataAddrBits-1:2]),
        .i_byteEnable (byteEnable),
        .i_writeData  (laneData),
        .i_write      (memWrite),
        .o_readData   (readData)
    );

    // Load lane selection
    assign shiftedRead = readData >> {byteOffset, 3'b000};
    assign shiftedHalf = readData >> {byteOffset[1], 4'b0000};
    assign loadByte    = shiftedRead[7:0];
    assign loadHalf    = shiftedHalf[15:0];

    // Sign or zero extension by width code
    always_comb begin
        case (i_funct3)
            RvTypes::FunctByte:  loadValue = {{(RvTypes::DataBits - 8){loadByte[7]}}, loadByte};
            RvTypes::FunctHalf:  loadValue = {{(RvTypes::DataBits - 16){loadHalf[15]}}, loadHalf};
            RvTypes::FunctByteU: loadValue = {{(RvTypes::DataBits - 8){1'b0}}, loadByte};
            RvTypes::FunctHalfU: loadValue = {{(RvTypes::DataBits - 16){1'b0}}, loadHalf};
            default:             loadValue = readData;  // LW
        endcase
    end

    assign o_result      = i_isLoad ? loadValue : i_aluResult;  // ALU value otherwise
    assign o_regWrEnable = i_regWrEnable;                       // Flush handled in MEM/WB

endmodule

// File: rtl/PipelineExMem.sv
module PipelineExMem (
    input  logic            i_clock,        // Clock
    input  logic            i_rstN,         // Async reset, active low
    input  logic            i_valid,        // Instruction present from EX
    input  RvTypes::Data    i_aluResult,    // ALU result, also memory address
    input  RvTypes::Data    i_storeData,    // rs2 value for stores
    input  RvTypes::RegAddr i_rd,           // Destination register
    input  logic            i_regWrEnable,  // Instruction writes rd
    input  logic            i_isLoad,       // Load instruction
    input  logic            i_isStore,      // Store instruction
    input  RvTypes::Funct3  i_funct3,       // Access width code

    output logic            o_valid,        // Instruction held in MEM
    output RvTypes::Data    o_aluResult,
    output RvTypes::Data    o_storeData,
    output RvTypes::RegAddr o_rd,
    output logic            o_regWrEnable,  // Already qualified by valid
    output logic            o_isLoad,       // Already qualified by valid
    output logic            o_isStore,      // Already qualified by valid
    output RvTypes::Funct3  o_funct3
);

    // Control bits, cleared by reset
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_valid       <= 1'b0;
            o_regWrEnable <= 1'b0;
            o_isLoad      <= 1'b0;
            o_isStore     <= 1'b0;
        end else begin
            o_valid       <= i_valid;
            o_regWrEnable <= i_valid & i_regWrEnable;  // Bubble never writes
            o_isLoad      <= i_valid & i_isLoad;
            o_isStore     <= i_valid & i_isStore;      // Bubble never stores
        end
    end

    // Payload, meaningless without the enables above
    always_ff @(posedge i_clock) begin
        o_aluResult <= i_aluResult;
        o_storeData <= i_storeData;
        o_rd        <= i_rd;
        o_funct3    <= i_funct3;
    end

endmodule

// File: rtl/PipelineMemWb.sv
module PipelineMemWb (
    input  logic            i_clock,        // Clock
    input  logic            i_rstN,         // Async reset, active low
    input  logic            i_flush,        // Drops the pending register write

    input  RvTypes::RegAddr i_regWrAddr,    // Destination register
    input  logic            i_regWrEnable,  // Write request from MEM
    input  RvTypes::Data    i_regWrData,    // Result from MEM

    output RvTypes::RegAddr o_regWrAddr,
    output logic            o_regWrEnable,  // Write request to the register file
    output RvTypes::Data    o_regWrData
);

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_regWrAddr   <= '0;
            o_regWrEnable <= 1'b0;
            o_regWrData   <= '0;
        end else begin
            o_regWrAddr   <= i_regWrAddr;
            o_regWrEnable <= i_flush ? 1'b0 : i_regWrEnable;  // Flushed instruction retires silently
            o_regWrData   <= i_regWrData;
        end
    end

endmodule

// File: rtl/RegisterFile.sv
module RegisterFile (
    input  logic            i_clock,      // Clock
    input  logic            i_rstN,       // Async reset, active low
    input  RvTypes::RegAddr i_wrAddr,     // Write port
    input  logic            i_wrEnable,
    input  RvTypes::Data    i_wrData,
    input  RvTypes::RegAddr i_rs1Addr,    // Read port 1
    input  RvTypes::RegAddr i_rs2Addr,    // Read port 2
    output RvTypes::Data    o_rs1Data,
    output RvTypes::Data    o_rs2Data
);

    RvTypes::Data regs [RvTypes::RegCount];  // regs[0] never written
    logic         wrActive;                  // Write to a real register

    assign wrActive = i_wrEnable && (i_wrAddr != '0);  // x0 writes ignored

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int idx = 0; idx < RvTypes::RegCount; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wrActive) begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

    // Reads see the pending write in the same cycle
    always_comb begin
        if (i_rs1Addr == '0)
            o_rs1Data = '0;
        else if (wrActive && (i_wrAddr == i_rs1Addr))
            o_rs1Data = i_wrData;                // Bypass
        else
            o_rs1Data = regs[i_rs1Addr];

        if (i_rs2Addr == '0)
            o_rs2Data = '0;
        else if (wrActive && (i_wrAddr == i_rs2Addr))
            o_rs2Data = i_wrData;                // Bypass
        else
            o_rs2Data = regs[i_rs2Addr];
    end

endmodule

// File: rtl/BackEndTop.sv
module BackEndTop (
    input  logic            i_clock,        // Clock
    input  logic            i_rstN,         // Async reset, active low

    input  logic            i_valid,        // Executed instruction present
    input  RvTypes::Data    i_aluResult,    // ALU result or byte address
    input  RvTypes::Data    i_storeData,    // Store value
    input  RvTypes::RegAddr i_rd,           // Destination register
    input  logic            i_regWrEnable,  // Writes rd
    input  logic            i_isLoad,
    input  logic            i_isStore,
    input  RvTypes::Funct3  i_funct3,       // Access width code
    input  logic            i_flush,        // Cancels the instruction in MEM

    input  RvTypes::RegAddr i_rs1Addr,      // Decode-side read ports
    input  RvTypes::RegAddr i_rs2Addr,
    output RvTypes::Data    o_rs1Data,
    output RvTypes::Data    o_rs2Data
);

    // EX/MEM outputs
    RvTypes::Data    exMemAluResult;
    RvTypes::Data    exMemStoreData;
    RvTypes::RegAddr exMemRd;
    logic            exMemRegWrEnable;
    logic            exMemIsLoad;
    logic            exMemIsStore;
    RvTypes::Funct3  exMemFunct3;

    // MEM stage outputs
    RvTypes::Data    memResult;
    logic            memRegWrEnable;

    // MEM/WB outputs
    RvTypes::RegAddr wbRegWrAddr;
    logic            wbRegWrEnable;
    RvTypes::Data    wbRegWrData;

    PipelineExMem i_pipelineExMem (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_valid       (i_valid),
        .i_aluResult   (i_aluResult),
        .i_storeData   (i_storeData),
        .i_rd          (i_rd),
        .i_regWrEnable (i_regWrEnable),
        .i_isLoad      (i_isLoad),
        .i_isStore     (i_isStore),
        .i_funct3      (i_funct3),
        .o_valid       (),                  // Enables already carry valid
        .o_aluResult   (exMemAluResult),
        .o_storeData   (exMemStoreData),
        .o_rd          (exMemRd),
        .o_regWrEnable (exMemRegWrEnable),
        .o_isLoad      (exMemIsLoad),
        .o_isStore     (exMemIsStore),
        .o_funct3      (exMemFunct3)
    );

    MemoryStage i_memoryStage (
        .i_clock       (i_clock),
        .i_flush       (i_flush),
        .i_regWrEnable (exMemRegWrEnable),
        .i_isLoad      (exMemIsLoad),
        .i_isStore     (exMemIsStore),
        .i_funct3      (exMemFunct3),
        .i_aluResult   (exMemAluResult),
        .i_storeData   (exMemStoreData),
        .o_result      (memResult),
        .o_regWrEnable (memRegWrEnable)
    );

    PipelineMemWb i_pipelineMemWb (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_flush       (i_flush),
        .i_regWrAddr   (exMemRd),           // rd bypasses MEM unchanged
        .i_regWrEnable (memRegWrEnable),
        .i_regWrData   (memResult),
        .o_regWrAddr   (wbRegWrAddr),
        .o_regWrEnable (wbRegWrEnable),
        .o_regWrData   (wbRegWrData)
    );

    RegisterFile i_registerFile (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_wrAddr   (wbRegWrAddr),
        .i_wrEnable (wbRegWrEnable),
        .i_wrData   (wbRegWrData),
        .i_rs1Addr  (i_rs1Addr),
        .i_rs2Addr  (i_rs2Addr),
        .o_rs1Data  (o_rs1Data),
        .o_rs2Data  (o_rs2Data)
    );

endmodule

// File: testbench/BackEnd_asserts.sv
module BackEnd_asserts (
    input  logic                             i_clock,        // DUT clock
    input  logic                             i_rstN,         // DUT reset, active low
    input  logic                             i_regWrEnable,  // MEM/WB enable into the register file
    input  RvTypes::RegAddr                  i_rs1Addr,      // Read port 1 address
    input  RvTypes::Data                     i_rs1Data,      // Read port 1 data
    input  logic                             i_flush,        // Flush of the instruction in MEM
    input  logic [RvTypes::DataAddrBits-1:2] i_wordAddr,     // Word addressed by MEM
    input  RvTypes::Data                     i_memory [RvTypes::DataMemWords]  // RAM contents
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;                      // Read by the testbench at the end

    // Write-back stays quiet while reset is held
    resetQuiet: assert property (@(posedge i_clock) !i_rstN |-> !i_regWrEnable)
        else begin
            failCount++;
            $error("register write enable high while reset is asserted");
        end

    // x0 is hardwired
    zeroReg: assert property (@(posedge i_clock) disable iff (!i_rstN)
                              (i_rs1Addr == '0) |-> (i_rs1Data == '0))
        else begin
            failCount++;
            $error("x0 read on rs1 returned %08h", i_rs1Data);
        end

    // A flushed store leaves its word untouched
    flushNoStore: assert property (@(posedge i_clock) disable iff (!i_rstN)
                                   i_flush |=> (i_memory[$past(i_wordAddr)]
                                                === $past(i_memory[i_wordAddr])))
        else begin
            failCount++;
            $error("data memory written in a flushed cycle");
        end

endmodule

bind BackEndTop BackEnd_asserts i_backEndAsserts (
    .i_clock       (i_clock),
    .i_rstN        (i_rstN),
    .i_regWrEnable (wbRegWrEnable),
    .i_rs1Addr     (i_rs1Addr),
    .i_rs1Data     (o_rs1Data),
    .i_flush       (i_flush),
    .i_wordAddr    (i_memoryStage.i_dataMemory.i_wordAddr),
    .i_memory      (i_memoryStage.i_dataMemory.memory)
);

// File: testbench/BackEndTb.sv
module BackEndTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod   = 2;                      // 4 ns clock
    localparam int ResetCycles  = 8;
    localparam int IdleCycles   = 34;                     // Sweep every register after reset
    localparam int AluCount     = 60;
    localparam int WordPairs    = 16;                     // Word store, then word load
    localparam int SubWordWords = 4;                      // Words for byte and half tests
    localparam int SubWordInstr = 59;                     // Instructions per such word
    localparam int FlushInstr   = 6;
    localparam int DrainCycles  = 36;                     // Full sweep after the last write
    localparam int TotalCycles  = ResetCycles + IdleCycles + AluCount + 1 + 2 * WordPairs
                                  + SubWordWords * SubWordInstr + FlushInstr + DrainCycles;
    localparam int TimeoutNs    = TotalCycles * 2 * HalfPeriod + 200;
    localparam int AddrTop      = RvTypes::DataAddrBits - 1;

    logic            i_clock;
    logic            i_rstN;
    logic            i_valid;
    RvTypes::Data    i_aluResult;
    RvTypes::Data    i_storeData;
    RvTypes::RegAddr i_rd;
    logic            i_regWrEnable;
    logic            i_isLoad;
    logic            i_isStore;
    RvTypes::Funct3  i_funct3;
    logic            i_flush;
    RvTypes::RegAddr i_rs1Addr;
    RvTypes::RegAddr i_rs2Addr;
    RvTypes::Data    o_rs1Data;
    RvTypes::Data    o_rs2Data;

    logic [31:0]     lcgState;
    int              checkCount;
    int              errorCount;
    int              assertFails;
    logic            checksEnabled;                       // Compare process runs once set

    RvTypes::Data    modelRegs [RvTypes::RegCount];       // Architectural registers
    logic [7:0]      modelMem [1 << RvTypes::DataAddrBits];  // Byte-wide data memory
    logic            heldValid;                           // Instruction in the model's MEM
    RvTypes::Data    heldAlu;
    RvTypes::Data    heldStoreData;
    RvTypes::RegAddr heldRd;
    logic            heldRegWr;
    logic            heldIsLoad;
    logic            heldIsStore;
    RvTypes::Funct3  heldFunct3;
    logic            focusValid;                          // Register touched at the last edge
    RvTypes::RegAddr focusRd;

    BackEndTop i_dut (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_valid       (i_valid),
        .i_aluResult   (i_aluResult),
        .i_storeData   (i_storeData),
        .i_rd          (i_rd),
        .i_regWrEnable (i_regWrEnable),
        .i_isLoad      (i_isLoad),
        .i_isStore     (i_isStore),
        .i_funct3      (i_funct3),
        .i_flush       (i_flush),
        .i_rs1Addr     (i_rs1Addr),
        .i_rs2Addr     (i_rs2Addr),
        .o_rs1Data     (o_rs1Data),
        .o_rs2Data     (o_rs2Data)
    );

    always #HalfPeriod i_clock = ~i_clock;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
        return lcgState;
    endfunction

    function automatic RvTypes::RegAddr randomDest();
        logic [31:0] rnd;
        rnd = nextRandom();
        return (rnd[31:27] == '0) ? 5'd1 : rnd[31:27];      // High bits, never x0
    endfunction

    function automatic RvTypes::DataAddr laneAddr(input RvTypes::DataAddr base, input int off);
        return {base[AddrTop:2], 2'(off)};
    endfunction

    // Expected load value from the byte memory, by RV32I width and sign rules
    function automatic RvTypes::Data expectedLoad(input RvTypes::DataAddr addr,
                                                  input RvTypes::Funct3 funct3);
        logic [7:0]   lane;
        logic [15:0]  half;
        RvTypes::Data word;
        RvTypes::Data result;
        lane = modelMem[addr];
        half = {modelMem[{addr[AddrTop:1], 1'b1}], modelMem[{addr[AddrTop:1], 1'b0}]};
        word = {modelMem[{addr[AddrTop:2], 2'd3}], modelMem[{addr[AddrTop:2], 2'd2}],
                modelMem[{addr[AddrTop:2], 2'd1}], modelMem[{addr[AddrTop:2], 2'd0}]};
        case (funct3)
            RvTypes::FunctByte:  result = {{24{lane[7]}}, lane};  // LB
            RvTypes::FunctHalf:  result = {{16{half[15]}}, half}; // LH
            RvTypes::FunctByteU: result = {24'h0, lane};
            RvTypes::FunctHalfU: result = {16'h0, half};
            default:             result = word;                   // LW, aligned down
        endcase
        return result;
    endfunction

    task automatic storeModel(input RvTypes::DataAddr addr, input RvTypes::Data data,
                              input RvTypes::Funct3 funct3);
        case (funct3)
            RvTypes::FunctByte: modelMem[addr] = data[7:0];
            RvTypes::FunctHalf: begin
                modelMem[{addr[AddrTop:1], 1'b0}] = data[7:0];
                modelMem[{addr[AddrTop:1], 1'b1}] = data[15:8];
            end
            RvTypes::FunctWord: begin
                modelMem[{addr[AddrTop:2], 2'd0}] = data[7:0];
                modelMem[{addr[AddrTop:2], 2'd1}] = data[15:8];
                modelMem[{addr[AddrTop:2], 2'd2}] = data[23:16];
                modelMem[{addr[AddrTop:2], 2'd3}] = data[31:24];
            end
            default: ;                                   // Not a store width
        endcase
    endtask

    // Effect of the instruction leaving MEM, readable from this edge on
    task automatic retireModel(input logic flushed);
        RvTypes::DataAddr addr;
        addr = heldAlu[AddrTop:0];
        if (heldRegWr && (heldRd != '0)) begin
            focusValid = 1'b1;                           // Read it back next cycle
            focusRd    = heldRd;
        end
        if (!flushed) begin
            if (heldIsStore)
                storeModel(addr, heldStoreData, heldFunct3);
            if (heldRegWr && (heldRd != '0))
                modelRegs[heldRd] = heldIsLoad ? expectedLoad(addr, heldFunct3) : heldAlu;
        end
    endtask

    always @(posedge i_clock) begin
        focusValid = 1'b0;
        if (!i_rstN) begin
            heldValid = 1'b0;
            for (int idx = 0; idx < RvTypes::RegCount; idx++)
                modelRegs[idx] = '0;
        end else begin
            if (heldValid)
                retireModel(i_flush);                    // Flush cancels the one in MEM
            heldValid     = i_valid;
            heldAlu       = i_aluResult;
            heldStoreData = i_storeData;
            heldRd        = i_rd;
            heldRegWr     = i_regWrEnable;
            heldIsLoad    = i_isLoad;
            heldIsStore   = i_isStore;
            heldFunct3    = i_funct3;
        end
    end

    task automatic checkRead(input string port, input RvTypes::RegAddr addr,
                             input RvTypes::Data got);
        checkCount++;
        if (got !== modelRegs[addr]) begin
            errorCount++;
            $display("FAIL %0t ns: %s x%0d read %08h, expected %08h",
                     $time, port, addr, got, modelRegs[addr]);
        end
    endtask

    // Compare process, fresh writes on rs1 through the bypass, sweep otherwise
    initial begin : compareProcess
        RvTypes::RegAddr sweep;
        sweep = '0;
        wait (checksEnabled);
        forever begin
            @(negedge i_clock);
            i_rs1Addr = focusValid ? focusRd : sweep;
            i_rs2Addr = ~sweep;
            #1;                                          // Mid low phase, reads settled
            checkRead("rs1", i_rs1Addr, o_rs1Data);
            checkRead("rs2", i_rs2Addr, o_rs2Data);
            sweep = sweep + 5'd1;
        end
    end

    task automatic issue(input logic isLoad, input logic isStore, input logic regWr,
                         input RvTypes::RegAddr rd, input RvTypes::Funct3 funct3,
                         input RvTypes::Data alu, input RvTypes::Data storeData,
                         input logic flush);
        @(negedge i_clock);
        i_valid       = 1'b1;
        i_isLoad      = isLoad;
        i_isStore     = isStore;
        i_regWrEnable = regWr;
        i_rd          = rd;
        i_funct3      = funct3;
        i_aluResult   = alu;
        i_storeData   = storeData;
        i_flush       = flush;                           // Acts on the previous instruction
    endtask

    task automatic aluOp(input RvTypes::RegAddr rd, input RvTypes::Data value);
        issue(1'b0, 1'b0, 1'b1, rd, RvTypes::FunctWord, value, '0, 1'b0);
    endtask

    task automatic storeOp(input RvTypes::DataAddr addr, input RvTypes::Data data,
                           input RvTypes::Funct3 funct3);
        issue(1'b0, 1'b1, 1'b0, '0, funct3, RvTypes::Data'(addr), data, 1'b0);
    endtask

    task automatic loadOp(input RvTypes::DataAddr addr, input RvTypes::RegAddr rd,
                          input RvTypes::Funct3 funct3);
        issue(1'b1, 1'b0, 1'b1, rd, funct3, RvTypes::Data'(addr), '0, 1'b0);
    endtask

    task automatic loadAllWidths(input RvTypes::DataAddr base);
        for (int off = 0; off < 4; off++) begin
            loadOp(laneAddr(base, off), randomDest(), RvTypes::FunctByte);
            loadOp(laneAddr(base, off), randomDest(), RvTypes::FunctByteU);
            loadOp(laneAddr(base, off), randomDest(), RvTypes::FunctHalf);
            loadOp(laneAddr(base, off), randomDest(), RvTypes::FunctHalfU);
            loadOp(laneAddr(base, off), randomDest(), RvTypes::FunctWord);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge i_clock);
            i_valid       = 1'b0;
            i_regWrEnable = 1'b0;
            i_isLoad      = 1'b0;
            i_isStore     = 1'b0;
            i_flush       = 1'b0;
        end
    endtask

    initial begin : stimulus
        logic [31:0]      rnd;
        RvTypes::DataAddr addr;
        RvTypes::RegAddr  rd;
        i_clock       = 1'b0;
        i_rstN        = 1'b0;
        i_valid       = 1'b0;
        i_aluResult   = '0;
        i_storeData   = '0;
        i_rd          = '0;
        i_regWrEnable = 1'b0;
        i_isLoad      = 1'b0;
        i_isStore     = 1'b0;
        i_funct3      = RvTypes::FunctWord;
        i_flush       = 1'b0;
        i_rs1Addr     = '0;
        i_rs2Addr     = '0;
        lcgState      = 32'd10732;
        checkCount    = 0;
        errorCount    = 0;
        checksEnabled = 1'b0;
        addr          = '0;
        repeat (ResetCycles) @(negedge i_clock);
        i_rstN        = 1'b1;
        checksEnabled = 1'b1;
        idle(IdleCycles);                                // All registers read zero

        aluOp(5'd0, 32'hDEADBEEF);                       // x0 stays zero
        for (int i = 0; i < AluCount; i++) begin
            rnd = nextRandom();
            aluOp(rnd[31:27], nextRandom());             // x0 hit now and then
        end

        for (int i = 0; i < WordPairs; i++) begin
            rnd  = nextRandom();
            addr = {rnd[23:16], 2'b00};
            storeOp(addr, nextRandom(), RvTypes::FunctWord);
            loadOp(addr, randomDest(), RvTypes::FunctWord);  // Back to back with the store
        end

        for (int w = 0; w < SubWordWords; w++) begin
            rnd  = nextRandom();
            addr = {rnd[23:16], 2'b00};
            storeOp(addr, nextRandom(), RvTypes::FunctWord);
            for (int off = 0; off < 4; off++) begin
                storeOp(laneAddr(addr, off), nextRandom(), RvTypes::FunctByte);
                loadOp(addr, randomDest(), RvTypes::FunctWord);  // Byte merged into the word
            end
            loadAllWidths(addr);
            loadOp(addr, randomDest(), RvTypes::FunctWord);  // Merged bytes
            for (int off = 0; off < 4; off++) begin
                storeOp(laneAddr(addr, off), nextRandom(), RvTypes::FunctHalf);  // Odd ones aligned down
                loadOp(addr, randomDest(), RvTypes::FunctWord);
            end
            loadAllWidths(addr);
            loadOp(addr, randomDest(), RvTypes::FunctWord);
        end

        // Flush of a register write, then of a store
        rd = randomDest();
        aluOp(rd, nextRandom());
        issue(1'b0, 1'b0, 1'b1, rd, RvTypes::FunctWord, nextRandom(), '0, 1'b0);
        issue(1'b0, 1'b0, 1'b1, randomDest(), RvTypes::FunctWord, nextRandom(), '0, 1'b1);
        issue(1'b0, 1'b1, 1'b0, '0, RvTypes::FunctWord, RvTypes::Data'(addr),
              nextRandom(), 1'b0);
        issue(1'b0, 1'b0, 1'b1, randomDest(), RvTypes::FunctWord, nextRandom(), '0, 1'b1);
        loadOp(addr, randomDest(), RvTypes::FunctWord);  // Old word still there
        idle(DrainCycles);

        assertFails = i_dut.i_backEndAsserts.failCount;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if ((errorCount == 0) && (assertFails == 0))
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin : watchdog
        #(TimeoutNs);
        $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: sources.f
common/RvTypes.sv
memoryStage/DataMemory.sv
memoryStage/MemoryStage.sv
rtl/PipelineExMem.sv
rtl/PipelineMemWb.sv
rtl/RegisterFile.sv
rtl/BackEndTop.sv
testbench/BackEnd_asserts.sv
testbench/BackEndTb.sv

// File: Makefile
TOP := BackEndTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
